// ==== spi_flash_reader.f ====
common/spi_flash_pkg.sv
common/flash_req_if.sv
common/flash_xfer_if.sv
rtl/flash_req_decode.sv
rtl/spi_shift_engine.sv
rtl/flash_result.sv
rtl/spi_flash_reader.sv
tb/spi_flash_model.sv
tb/tb_spi_flash_reader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SPI flash reader testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f spi_flash_reader.f \
	--top-module tb_spi_flash_reader \
	-Mdir obj_dir

out=$(./obj_dir/Vtb_spi_flash_reader)
echo "$out"

if grep -q "Simulation finished: PASS" <<< "$out"; then
	exit 0
else
	exit 1
fi

// ==== tb/tb_spi_flash_reader.sv ====
// Clock, reset, LFSR stimulus, reference model, compare tasks, watchdog and report
`timescale 1ns/1ns
`default_nettype none

module tb_spi_flash_reader import spi_flash_pkg::*; ();

	// Operation codes of the stimulus
	localparam int OP_MEM_RD = 0;
	localparam int OP_MEM_WR = 1;
	localparam int OP_USER = 2;
	localparam int OP_END = 3;
	localparam int OP_CFG_RD = 4;
	localparam int NUM_REQ = 64;
	// Edges after the accepting edge until acknowledge shows
	localparam int READ_ACK_EDGES = 66;
	localparam int USER_ACK_EDGES = 10;
	localparam int IMM_ACK_EDGES = 0;

	logic i_clk;
	logic i_reset;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [BUS_AW-1:0] i_wb_addr;
	logic [DATA_W-1:0] i_wb_data;
	logic o_wb_ack;
	logic [DATA_W-1:0] o_wb_data;
	logic o_spi_cs_n;
	logic o_spi_sck;
	logic o_spi_mosi;
	logic spi_miso;
	logic [BYTE_W-1:0] frame_cmd;
	logic [23:0] frame_addr;
	logic [BYTE_W-1:0] frame_user;

	// Reference state
	logic [DATA_W-1:0] ref_table [0:63];
	logic ref_user_mode;
	logic [BYTE_W-1:0] ref_rx_low;
	logic [BYTE_W-1:0] ref_prev_user;
	logic [15:0] lfsr_state;
	int errors;
	int tests_run;
	int tests_bad;

	spi_flash_reader DUT (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we (i_wb_we),
		.i_wb_addr (i_wb_addr),
		.i_wb_data (i_wb_data),
		.o_wb_ack (o_wb_ack),
		.o_wb_data (o_wb_data),
		.o_spi_cs_n (o_spi_cs_n),
		.o_spi_sck (o_spi_sck),
		.o_spi_mosi (o_spi_mosi),
		.i_spi_miso (spi_miso)
	);

	spi_flash_model u_flash (
		.i_clk (i_clk),
		.i_cs_n (o_spi_cs_n),
		.i_sck (o_spi_sck),
		.i_mosi (o_spi_mosi),
		.o_miso (spi_miso),
		.o_cmd (frame_cmd),
		.o_addr (frame_addr),
		.o_user_byte (frame_user)
	);

	always #5 i_clk = ~i_clk;

	////////////////////////////////////////////////////////////////////
	// Random numbers and compare tasks
	////////////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return v;
	endfunction

	task automatic check_word(input string name, input read_word_u got, input read_word_u exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got.word, exp.word);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [23:0] got,
		input logic [23:0] exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Bus access and reference model
	////////////////////////////////////////////////////////////////////

	// Called 1 ns after an edge; returns 1 ns after the edge that follows acknowledge
	task automatic bus_access(input logic we, input logic [BUS_AW-1:0] addr,
		input logic [DATA_W-1:0] data, output read_word_u rdata, output int edges,
		output int clocks);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = we;
		i_wb_addr = addr;
		i_wb_data = data;
		@(posedge i_clk);
		#1;
		edges = 0;
		clocks = 0;
		while (!o_wb_ack && edges < 200)
		begin
			if (o_spi_sck)
				clocks++;
			@(posedge i_clk);
			#1;
			edges++;
		end
		if (!o_wb_ack)
		begin
			$display("No acknowledge within 200 cycles at t=%0t", $time);
			errors++;
		end
		rdata.word = o_wb_data;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		@(posedge i_clk);
		#1;
		// A transfer launched behind the acknowledge shows its clock here
		if (o_spi_sck)
			clocks++;
	endtask

	// One request of the given kind with random fields checked against the reference
	task automatic run_op(input int op);
		logic [WORD_AW-1:0] waddr;
		logic [DATA_W-1:0] data;
		read_word_u got;
		read_word_u exp;
		int edges;
		int clocks;
		waddr = rand_bits(WORD_AW);
		data = rand_bits(DATA_W);
		exp.word = '0;
		case (op)
			OP_MEM_RD:
			begin
				bus_access(1'b0, {1'b0, waddr}, data, got, edges, clocks);
				if (ref_user_mode)
				begin
					exp.ctl.cs_n = 1'b0;
					exp.ctl.rx_byte = ref_rx_low;
					check_count("latency", edges, IMM_ACK_EDGES);
					check_count("sck count", clocks, 0);
				end
				else
				begin
					exp.word = ref_table[waddr[5:0]];
					ref_rx_low = exp.word[7:0];
					check_count("latency", edges, READ_ACK_EDGES);
					check_count("sck count", clocks, 64);
					check_byte("frame_cmd", frame_cmd, 8'h03);
					check_addr("frame_addr", frame_addr, {waddr, 2'b00});
				end
				check_word("o_wb_data", got, exp);
			end
			OP_MEM_WR:
			begin
				bus_access(1'b1, {1'b0, waddr}, data, got, edges, clocks);
				check_count("latency", edges, IMM_ACK_EDGES);
				check_count("sck count", clocks, 0);
			end
			OP_USER:
			begin
				data[8] = 1'b0;
				// Keep the first byte distinct from the read command
				if (data[7:0] == 8'h03)
					data[7] = 1'b1;
				bus_access(1'b1, {1'b1, waddr}, data, got, edges, clocks);
				check_count("latency", edges, USER_ACK_EDGES);
				check_count("sck count", clocks, 8);
				check_byte("mosi byte", frame_user, data[7:0]);
				ref_rx_low = ref_prev_user ^ 8'hA5;
				ref_prev_user = data[7:0];
				ref_user_mode = 1'b1;
			end
			OP_END:
			begin
				data[8] = 1'b1;
				bus_access(1'b1, {1'b1, waddr}, data, got, edges, clocks);
				check_count("latency", edges, IMM_ACK_EDGES);
				check_count("sck count", clocks, 0);
				ref_user_mode = 1'b0;
			end
			default:
			begin
				bus_access(1'b0, {1'b1, waddr}, data, got, edges, clocks);
				exp.ctl.cs_n = !ref_user_mode;
				exp.ctl.rx_byte = ref_rx_low;
				check_count("latency", edges, IMM_ACK_EDGES);
				check_count("sck count", clocks, 0);
				check_word("o_wb_data", got, exp);
			end
		endcase
		// Chip select level one edge after acknowledge
		check_bit("o_spi_cs_n", o_spi_cs_n, !ref_user_mode);
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("test %s: ok", name);
		else
		begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////

	initial
	begin
		int e0;
		int op;
		i_clk = 1'b0;
		i_reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		lfsr_state = 16'd56;
		errors = 0;
		tests_run = 0;
		tests_bad = 0;
		ref_user_mode = 1'b0;
		ref_rx_low = '0;
		ref_prev_user = '0;
		for (int i = 0; i < 64; i++)
		begin
			ref_table[i] = rand_bits(DATA_W);
			u_flash.table_mem[i] = ref_table[i];
		end
		repeat (16) @(posedge i_clk);
		#1;
		i_reset = 1'b0;

		e0 = errors;
		check_bit("o_spi_cs_n", o_spi_cs_n, 1'b1);
		check_bit("o_spi_sck", o_spi_sck, 1'b0);
		check_bit("o_wb_ack", o_wb_ack, 1'b0);
		report_test("reset state", e0);

		e0 = errors;
		repeat (12) run_op(OP_MEM_RD);
		report_test("memory reads", e0);

		e0 = errors;
		repeat (4) run_op(OP_MEM_WR);
		report_test("memory writes", e0);

		e0 = errors;
		repeat (4)
		begin
			run_op(OP_USER);
			run_op(OP_CFG_RD);
		end
		report_test("user bytes", e0);

		e0 = errors;
		repeat (3) run_op(OP_MEM_RD);
		report_test("memory during user mode", e0);

		e0 = errors;
		run_op(OP_END);
		run_op(OP_CFG_RD);
		run_op(OP_MEM_RD);
		report_test("leave user mode", e0);

		// Random mix of all operations
		e0 = errors;
		repeat (20)
		begin
			op = rand_bits(3);
			if (op > OP_CFG_RD)
				op = OP_MEM_RD;
			run_op(op);
		end
		run_op(OP_END);
		report_test("random mix", e0);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_bad, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Watchdog sized from the request count
	initial
	begin
		#((NUM_REQ * 70 + 300) * 10);
		$display("Watchdog expired, the run did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/spi_flash_model.sv ====
// Behavioural SPI NOR flash with frame decoder, word table, MISO driver and frame record
`timescale 1ns/1ns
`default_nettype none

module spi_flash_model import spi_flash_pkg::*; (
	input wire logic i_clk,
	input wire logic i_cs_n,
	input wire logic i_sck,
	input wire logic i_mosi,
	output logic o_miso,
	output logic [BYTE_W-1:0] o_cmd,
	output logic [23:0] o_addr,
	output logic [BYTE_W-1:0] o_user_byte
);

	// Word table filled by the testbench and indexed by the low 6 word address bits
	logic [DATA_W-1:0] table_mem [0:63];
	logic [31:0] rx_bits;
	logic [23:0] addr_r;
	logic [BYTE_W-1:0] last_byte;
	logic [BYTE_W-1:0] reply;
	logic is_read;
	int bit_idx;

	initial
	begin
		o_miso = 1'b0;
		o_cmd = '0;
		o_addr = '0;
		o_user_byte = '0;
		last_byte = '0;
		reply = '0;
		is_read = 1'b0;
		bit_idx = 0;
	end

	// Each edge that sees a serial clock takes one MOSI bit
	// and places the MISO bit for that same clock
	always @(posedge i_clk)
	begin
		if (i_cs_n)
		begin
			bit_idx = 0;
			is_read = 1'b0;
		end
		else if (i_sck)
		begin
			if (bit_idx % 8 == 0)
				reply = last_byte ^ 8'hA5;
			rx_bits = {rx_bits[30:0], i_mosi};
			// First byte of every frame is recorded and decides the frame kind
			if (bit_idx == 7)
			begin
				o_cmd <= rx_bits[7:0];
				if (rx_bits[7:0] == READ_OPCODE)
					is_read = 1'b1;
			end
			if (is_read && bit_idx == 31)
			begin
				addr_r = rx_bits[23:0];
				o_addr <= rx_bits[23:0];
			end
			if (is_read && bit_idx >= 32)
				o_miso <= table_mem[addr_r[7:2]][63-bit_idx];
			else if (!is_read)
			begin
				// User byte answered with the previous byte xor A5
				o_miso <= reply[7 - (bit_idx % 8)];
				if (bit_idx % 8 == 7)
				begin
					last_byte = rx_bits[7:0];
					o_user_byte <= rx_bits[7:0];
				end
			end
			bit_idx = bit_idx + 1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/spi_flash_reader.sv ====
// Top level: Wishbone classic slave to SPI NOR flash read controller
`timescale 1ns/1ns
`default_nettype none

module spi_flash_reader import spi_flash_pkg::*; (
	input wire logic i_clk,
	input wire logic i_reset,
	// Wishbone classic slave
	input wire logic i_wb_cyc,
	input wire logic i_wb_stb,
	input wire logic i_wb_we,
	input wire logic [BUS_AW-1:0] i_wb_addr,
	input wire logic [DATA_W-1:0] i_wb_data,
	output logic o_wb_ack,
	output logic [DATA_W-1:0] o_wb_data,
	// SPI flash pins
	output logic o_spi_cs_n,
	output logic o_spi_sck,
	output logic o_spi_mosi,
	input wire logic i_spi_miso
);

	// Decode to result side band
	logic imm_ack;
	logic ctl_sel;
	logic arm;

	// Request path into the engine, timing path out of it
	flash_req_if u_req_if ();
	flash_xfer_if u_xfer_if ();

	// Bus side, one request at a time
	flash_req_decode u_decode (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.i_cyc (i_wb_cyc),
		.i_stb (i_wb_stb),
		.i_we (i_wb_we),
		.i_addr (i_wb_addr),
		.i_data (i_wb_data),
		.req (u_req_if.decoder),
		.o_imm_ack (imm_ack),
		.o_ctl_sel (ctl_sel),
		.o_arm (arm)
	);

	// Serial side, owns chip select and clock
	spi_shift_engine u_engine (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.req (u_req_if.engine),
		.xfer (u_xfer_if.engine),
		.o_spi_cs_n (o_spi_cs_n),
		.o_spi_sck (o_spi_sck),
		.o_spi_mosi (o_spi_mosi)
	);

	// MISO capture and bus return
	flash_result u_result (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.i_spi_miso (i_spi_miso),
		.i_imm_ack (imm_ack),
		.i_ctl_sel (ctl_sel),
		.i_arm (arm),
		.xfer (u_xfer_if.result),
		.o_ack (o_wb_ack),
		.o_data (o_wb_data)
	);

endmodule

`default_nettype wire

// ==== rtl/flash_result.sv ====
// Result stage: MISO capture, returned word forming, Wishbone acknowledge
`timescale 1ns/1ns
`default_nettype none

module flash_result import spi_flash_pkg::*; (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_spi_miso,
	input wire logic i_imm_ack,
	input wire logic i_ctl_sel,
	input wire logic i_arm,
	flash_xfer_if.result xfer,
	output logic o_ack,
	output logic [DATA_W-1:0] o_data
);

	logic [DATA_W-1:0] rx_sr;
	read_word_u ret_word;

	//////////////////////////////////////////////////////////////////////
	// MISO capture
	//////////////////////////////////////////////////////////////////////

	// Bit placed by the flash during the serial clock cycle
	// taken on the edge marked by sample, MSB first
	always_ff @(posedge i_clk)
	begin
		if (i_arm)
			rx_sr <= '0;
		else if (xfer.sample)
		begin
			if (xfer.user_mode)
				// Only the last byte matters in user mode
				rx_sr <= {{(DATA_W-BYTE_W){1'b0}}, rx_sr[BYTE_W-2:0], i_spi_miso};
			else
				rx_sr <= {rx_sr[DATA_W-2:0], i_spi_miso};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Returned word
	//////////////////////////////////////////////////////////////////////

	// Flash view by default
	// control view keeps the low byte and overlays the chip select level
	always_comb
	begin
		ret_word.word = rx_sr;
		if (i_ctl_sel)
		begin
			ret_word.ctl.pad = '0;
			ret_word.ctl.cs_n = xfer.cs_n;
		end
	end

	assign o_data = ret_word.word;

	// Serial transfer finished, or nothing to clock
	assign o_ack = xfer.done || i_imm_ack;

	// One request in flight, so acknowledges never run back to back
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_ack |=> !o_ack);

endmodule

`default_nettype wire

// ==== rtl/spi_shift_engine.sv ====
// SPI shift engine: bit counter, chip select, serial clock, MOSI shifter, user mode flag
`timescale 1ns/1ns
`default_nettype none

module spi_shift_engine import spi_flash_pkg::*; (
	input wire logic i_clk,
	input wire logic i_reset,
	flash_req_if.engine req,
	flash_xfer_if.engine xfer,
	output logic o_spi_cs_n,
	output logic o_spi_sck,
	output logic o_spi_mosi
);

	logic [CNT_W-1:0] bit_cnt;
	logic [DATA_W-1:0] tx_sr;
	logic start_any;
	logic sample_r;
	logic last_sample;
	logic done_r;
	logic busy_r;
	logic cs_n_r;
	logic user_mode_r;

	assign start_any = req.start_read || req.start_user;

	//////////////////////////////////////////////////////////////////////
	// Bit timing
	//////////////////////////////////////////////////////////////////////

	// One serial clock per cycle while bits remain
	assign o_spi_sck = (bit_cnt != '0);

	// Sample trails the serial clock by a cycle
	// last one is seen when the clock has already stopped
	assign last_sample = sample_r && !o_spi_sck;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			bit_cnt <= '0;
			sample_r <= 1'b0;
			done_r <= 1'b0;
			busy_r <= 1'b0;
		end
		else
		begin
			sample_r <= o_spi_sck;
			done_r <= last_sample;
			if (start_any)
			begin
				bit_cnt <= req.start_read ? READ_BITS : USER_BITS;
				busy_r <= 1'b1;
			end
			else
			begin
				if (bit_cnt != '0)
					bit_cnt <= bit_cnt - 1'b1;
				// Free again once the final bit is captured
				if (last_sample)
					busy_r <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Chip select and user mode
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			cs_n_r <= 1'b1;
			user_mode_r <= 1'b0;
		end
		else if (req.start_read)
			cs_n_r <= 1'b0;
		else if (req.start_user)
		begin
			// Software keeps the flash selected across bytes
			cs_n_r <= 1'b0;
			user_mode_r <= 1'b1;
		end
		else if (req.end_user)
		begin
			cs_n_r <= 1'b1;
			user_mode_r <= 1'b0;
		end
		else if (done_r && !user_mode_r)
			// Memory read over, deselect the cycle after acknowledge
			cs_n_r <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// MOSI shifter
	//////////////////////////////////////////////////////////////////////

	// Command and 24 bit byte address, or the user byte, top bit first
	always_ff @(posedge i_clk)
	begin
		if (req.start_read)
			tx_sr <= {READ_OPCODE, req.word_addr, 2'b00};
		else if (req.start_user)
			tx_sr <= {req.tx_byte, {(DATA_W-BYTE_W){1'b0}}};
		else if (o_spi_sck)
			// Zero fill once command and address are out
			tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
	end

	assign o_spi_mosi = tx_sr[DATA_W-1];
	assign o_spi_cs_n = cs_n_r;

	// Status back to the decoder
	assign req.busy = busy_r;
	assign req.user_mode = user_mode_r;

	// Timing to the result stage
	assign xfer.sample = sample_r;
	assign xfer.done = done_r;
	assign xfer.user_mode = user_mode_r;
	assign xfer.cs_n = cs_n_r;

	// Clock never runs with the flash deselected
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_spi_cs_n |-> !o_spi_sck);

endmodule

`default_nettype wire

// ==== rtl/flash_req_decode.sv ====
// Wishbone request decoder: accepts one request, issues serial transfers or direct acknowledges
`timescale 1ns/1ns
`default_nettype none

module flash_req_decode import spi_flash_pkg::*; (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_cyc,
	input wire logic i_stb,
	input wire logic i_we,
	input wire logic [BUS_AW-1:0] i_addr,
	input wire logic [DATA_W-1:0] i_data,
	flash_req_if.decoder req,
	output logic o_imm_ack,
	output logic o_ctl_sel,
	output logic o_arm
);

	logic pending;
	logic accept;
	logic cfg_space;
	logic user_wr;
	logic user_end;
	logic mem_rd;
	logic start_read_r;
	logic start_user_r;
	logic end_user_r;
	logic [WORD_AW-1:0] word_addr_r;
	logic [BYTE_W-1:0] tx_byte_r;

	// New request only once the previous one is fully acknowledged
	assign accept = i_cyc && i_stb && !pending && !req.busy;

	//////////////////////////////////////////////////////////////////////
	// Request classification
	//////////////////////////////////////////////////////////////////////

	assign cfg_space = i_addr[BUS_AW-1];
	// Config write, bit 8 low: send a byte and hold chip select
	assign user_wr = cfg_space && i_we && !i_data[CS_BIT];
	// Config write, bit 8 high: release the flash
	assign user_end = cfg_space && i_we && i_data[CS_BIT];
	// Memory read only goes to the flash outside user mode
	assign mem_rd = !cfg_space && !i_we && !req.user_mode;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			pending <= 1'b0;
			start_read_r <= 1'b0;
			start_user_r <= 1'b0;
			end_user_r <= 1'b0;
			o_imm_ack <= 1'b0;
			o_arm <= 1'b0;
			o_ctl_sel <= 1'b0;
		end
		else
		begin
			start_read_r <= accept && mem_rd;
			start_user_r <= accept && user_wr;
			end_user_r <= accept && user_end;
			// Everything that does not clock the flash
			o_imm_ack <= accept && !mem_rd && !user_wr;
			// Clear the receive register ahead of a transfer
			o_arm <= accept && (mem_rd || user_wr);
			// Reads in config space or during user mode see the control word
			if (accept)
				o_ctl_sel <= !i_we && (cfg_space || req.user_mode);
			// Held through the start pulse and the whole engine busy window
			if (accept)
				pending <= 1'b1;
			else if (pending && !req.busy && !start_read_r && !start_user_r)
				pending <= 1'b0;
		end
	end

	// Transfer fields, taken by the engine with the start pulse
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			word_addr_r <= i_addr[WORD_AW-1:0];
			tx_byte_r <= i_data[BYTE_W-1:0];
		end
	end

	assign req.start_read = start_read_r;
	assign req.start_user = start_user_r;
	assign req.end_user = end_user_r;
	assign req.word_addr = word_addr_r;
	assign req.tx_byte = tx_byte_r;

	// Engine must be idle whenever a new transfer is launched
	assert property (@(posedge i_clk) disable iff (i_reset)
		(req.start_read || req.start_user) |-> !req.busy);

endmodule

`default_nettype wire

// ==== common/flash_xfer_if.sv ====
// Interface: serial timing and chip select state from the shift engine to the result stage
`timescale 1ns/1ns
`default_nettype none

interface flash_xfer_if ();

	// High in the cycle after each serial clock, MISO bit is ready
	logic sample;
	// One pulse once the last bit has been taken in
	logic done;
	// Receive only the low byte while software owns the flash
	logic user_mode;
	// Present chip select level, reported in the control word
	logic cs_n;

	// Shift engine side
	modport engine (
		output sample, done, user_mode, cs_n
	);

	// Result stage side
	modport result (
		input sample, done, user_mode, cs_n
	);

endinterface

`default_nettype wire

// ==== common/flash_req_if.sv ====
// Interface: transfer requests from the Wishbone decoder to the SPI shift engine
`timescale 1ns/1ns
`default_nettype none

interface flash_req_if import spi_flash_pkg::*; ();

	// Single cycle start of a 64 clock memory read
	logic start_read;
	// Single cycle start of an 8 clock user byte
	logic start_user;
	// Word address, taken by the engine with start_read
	logic [WORD_AW-1:0] word_addr;
	// Byte to send, taken by the engine with start_user
	logic [BYTE_W-1:0] tx_byte;
	// Leave user mode, release chip select
	logic end_user;
	// Engine has a transfer in flight
	logic busy;
	// Chip select is held low by software
	logic user_mode;

	// Decoder issues requests and watches engine state
	modport decoder (
		output start_read, start_user, word_addr, tx_byte, end_user,
		input busy, user_mode
	);

	// Engine consumes requests and reports its state
	modport engine (
		input start_read, start_user, word_addr, tx_byte, end_user,
		output busy, user_mode
	);

endinterface

`default_nettype wire

// ==== common/spi_flash_pkg.sv ====
// Package: bus and flash widths, read opcode, serial bit counts, returned word types
`default_nettype none

package spi_flash_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus geometry
	//////////////////////////////////////////////////////////////////////

	// Wishbone data word
	localparam int DATA_W = 32;
	// Flash word address, byte address drops the two low zero bits
	localparam int WORD_AW = 22;
	// One extra bus address bit, top bit selects configuration space
	localparam int BUS_AW = WORD_AW + 1;
	// Width of a single SPI byte
	localparam int BYTE_W = 8;
	// Control word bit that carries chip select
	localparam int CS_BIT = 8;

	//////////////////////////////////////////////////////////////////////
	// Serial framing
	//////////////////////////////////////////////////////////////////////

	// Plain serial read command
	localparam logic [BYTE_W-1:0] READ_OPCODE = 8'h03;
	// Bit counter width, wide enough for a whole memory read
	localparam int CNT_W = 7;
	// 8 command + 24 address + 32 data clocks
	localparam logic [CNT_W-1:0] READ_BITS = 7'd64;
	// One byte per user mode write
	localparam logic [CNT_W-1:0] USER_BITS = 7'd8;

	//////////////////////////////////////////////////////////////////////
	// Returned data word
	//////////////////////////////////////////////////////////////////////

	// Control view, upper bits always zero
	typedef struct packed {
		logic [DATA_W-BYTE_W-2:0] pad;
		logic cs_n;
		logic [BYTE_W-1:0] rx_byte;
	} ctl_word_t;

	// Same bus word, either raw flash data or the control view
	typedef union packed {
		logic [DATA_W-1:0] word;
		ctl_word_t ctl;
	} read_word_u;

endpackage

`default_nettype wire
